// ==== vlog.f ====
source/m_isa_pkg.sv
source/m_uop_pkg.sv
source/m_decode.sv
source/m_multiplier.sv
source/m_divider.sv
source/m_result.sv
source/m_unit.sv
sim/tb_clock.sv
sim/m_unit_properties.sv
sim/m_unit_tb.sv

// ==== Bender.yml ====
package:
  name: m_unit

sources:
  # packages first, then the RTL in dependency order
  - source/m_isa_pkg.sv
  - source/m_uop_pkg.sv
  - source/m_decode.sv
  - source/m_multiplier.sv
  - source/m_divider.sv
  - source/m_result.sv
  - source/m_unit.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/m_unit_properties.sv
      - sim/m_unit_tb.sv

// ==== sim/m_unit_tb.sv ====
// m_unit testbench: directed tests, reference model, compare tasks, watchdog, report
`timescale 1ns/1ps

module m_unit_tb;
	import m_isa_pkg::*;

	localparam int XLEN    = 32;
	localparam int MUL_LAT = 4;  // start to done with MUL_STAGES = 2
	localparam int DIV_LAT = 34;
	localparam int N_RAND  = 6;
	localparam int NUM_OPS = 8 * (4 + N_RAND) + 8 + 2;
	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic            clk_i;
	logic            rst_n_i;
	logic            start_i;
	m_funct3_e       funct3_i;
	logic [XLEN-1:0] rs1_i;
	logic [XLEN-1:0] rs2_i;
	logic            busy_o;
	logic            done_o;
	logic [XLEN-1:0] result_o;

	int              err_value = 0;
	int              err_latency = 0;
	int              err_other = 0;
	logic [31:0]     rng_state = 32'h0a813505;
	// sign-edge operand pairs
	logic [XLEN-1:0] edge_a [4] = '{MOST_NEG, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0007};
	logic [XLEN-1:0] edge_b [4] = '{32'hffff_ffff, MOST_NEG, 32'h7fff_ffff, 32'hffff_fffe};

	tb_clock #(.PERIOD_NS(20.0), .RESET_CYCLES(4)) u_clock (.clk_o(clk_i), .rst_n_o(rst_n_i));

	m_unit #(.XLEN(XLEN), .MUL_STAGES(2)) u_dut (
		.clk_i, .rst_n_i, .start_i, .funct3_i, .rs1_i, .rs2_i, .busy_o, .done_o, .result_o
	);

	bind m_unit m_unit_properties u_props (
		.clk_i, .rst_n_i, .done_i(done_o), .busy_i(busy_o),
		.mul_go_i(mul_go), .div_go_i(div_go)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// expected result from 64-bit arithmetic plus the divide corner rules
	function automatic logic [XLEN-1:0] model(input m_funct3_e f, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] p;
		sa = longint'(signed'(a));
		sb = longint'(signed'(b));
		ua = longint'({32'b0, a});
		ub = longint'({32'b0, b});
		if (f[2] && b == '0) return f[1] ? a : '1;
		if ((f == DIV || f == REM) && a == MOST_NEG && b == '1) return f[1] ? '0 : MOST_NEG;
		case (f)
			MUL, MULH: p = sa * sb;
			MULHSU:    p = sa * ub;
			MULHU:     p = ua * ub;
			DIV:       p = sa / sb; // truncates toward zero
			DIVU:      p = ua / ub;
			REM:       p = sa % sb; // takes the dividend sign
			default:   p = ua % ub;
		endcase
		return (f == MUL || f[2]) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
	endfunction

	task automatic compare_word(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, got %h", name, exp, act);
			err_value++;
		end
	endtask

	task automatic compare_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s latency: expected %0d, got %0d", name, exp, act);
			err_latency++;
		end
	endtask

	task automatic run_op(input m_funct3_e f, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		string name;
		int    cycles;
		name = $sformatf("%s %h %h", f.name(), a, b);
		@(posedge clk_i);
		start_i  <= 1'b1;
		funct3_i <= f;
		rs1_i    <= a;
		rs2_i    <= b;
		@(posedge clk_i);
		start_i <= 1'b0;
		cycles = 1;
		@(negedge clk_i);
		while (!done_o && cycles < 2 * DIV_LAT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (!done_o) begin
			$display("%s: done_o did not arrive within %0d cycles", name, cycles);
			err_other++;
		end else begin
			compare_word(name, model(f, a, b), result_o);
			compare_latency(name, f[2] ? DIV_LAT : MUL_LAT, cycles);
		end
	endtask

	task automatic test_reset();
		wait (rst_n_i === 1'b1);
		@(negedge clk_i);
		compare_word("reset busy_o and done_o", '0, {busy_o, done_o});
		compare_word("reset result_o", '0, result_o);
	endtask

	task automatic test_family(input logic is_div);
		m_funct3_e       f;
		logic [XLEN-1:0] b;
		for (int k = 0; k < 4; k++) begin
			f = m_funct3_e'({is_div, k[1:0]});
			for (int i = 0; i < 4; i++) run_op(f, edge_a[i], edge_b[i]);
			for (int i = 0; i < N_RAND; i++) begin
				rng_state = xorshift32(rng_state);
				b = rng_state;
				rng_state = xorshift32(rng_state);
				if (is_div) b = $signed(b) >>> b[4:0]; // shorter divisors, sign kept
				run_op(f, rng_state, b);
			end
		end
	endtask

	task automatic test_corners();
		for (int k = 4; k < 8; k++) begin
			run_op(m_funct3_e'(k), 32'h8765_4321, '0);
			run_op(m_funct3_e'(k), MOST_NEG, '1);
		end
	endtask

	task automatic test_busy();
		int extra;
		extra = 0;
		fork
			run_op(DIVU, 32'd1000, 32'd7);
			begin
				repeat (3) @(posedge clk_i);
				start_i  <= 1'b1; // lands while the divide runs
				funct3_i <= MUL;
				rs1_i    <= 32'd3;
				rs2_i    <= 32'd5;
				@(negedge clk_i);
				compare_word("busy_o at second start", 32'd1, busy_o);
				@(posedge clk_i);
				start_i <= 1'b0;
			end
		join
		@(negedge clk_i);
		compare_word("busy_o after done_o", '0, busy_o);
		repeat (DIV_LAT) begin
			@(negedge clk_i);
			if (done_o) extra++;
		end
		if (extra != 0) begin
			$display("a start issued while busy produced %0d extra done_o pulses", extra);
			err_other++;
		end
	endtask

	initial begin
		start_i  = 1'b0;
		funct3_i = MUL;
		rs1_i    = '0;
		rs2_i    = '0;
		test_reset();
		test_family(1'b0);
		test_family(1'b1);
		test_corners();
		test_busy();
		$display("errors: value %0d, latency %0d, other %0d", err_value, err_latency, err_other);
		if (err_value + err_latency + err_other == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		repeat (NUM_OPS * 40 + 20) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, tests did not finish", NUM_OPS * 40 + 20);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== sim/m_unit_properties.sv ====
// concurrent checks on the done pulse, the busy level and execute dispatch of m_unit
`timescale 1ns/1ps

module m_unit_properties (
	input logic clk_i,
	input logic rst_n_i,
	input logic done_i,
	input logic busy_i,
	input logic mul_go_i,
	input logic div_go_i
);

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_i |=> !done_i)
		else $error("done_o high on two consecutive cycles");

	a_busy_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$fell(busy_i) |-> $past(done_i))
		else $error("busy_o fell without a done_o on the cycle before");

	a_one_go: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(mul_go_i && div_go_i))
		else $error("mul_go and div_go high together");

endmodule

// ==== sim/tb_clock.sv ====
// clock and synchronous reset generator for the testbench
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS    = 20.0,
	parameter int  RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1; // released on a rising edge
	end

endmodule

// ==== source/m_unit.sv ====
// top of the M-extension execute unit: decode, multiplier, divider, result stage
`timescale 1ns/1ps

module m_unit #(
	parameter int XLEN       = 32,
	parameter int MUL_STAGES = 2
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 start_i,
	input  m_isa_pkg::m_funct3_e funct3_i,
	input  logic [XLEN-1:0]      rs1_i,
	input  logic [XLEN-1:0]      rs2_i,
	output logic                 busy_o,
	output logic                 done_o,
	output logic [XLEN-1:0]      result_o
);
	import m_uop_pkg::*;

	logic              mul_go;
	logic              div_go;
	logic [XLEN-1:0]   a_mag;
	logic [XLEN-1:0]   b_mag;
	logic [XLEN-1:0]   dividend_raw;
	m_unit_sel_e       unit_sel;
	m_rsel_e           rsel;
	logic              neg_res;
	logic              div_zero;
	logic              div_ovf;
	logic [2*XLEN-1:0] product;
	logic              mul_done;
	logic [XLEN-1:0]   quotient;
	logic [XLEN-1:0]   remainder;
	logic              div_done;

	m_decode #(.XLEN(XLEN)) u_decode (
		.clk_i, .rst_n_i, .start_i, .funct3_i, .rs1_i, .rs2_i,
		.done_i(done_o), .busy_o,
		.mul_go_o(mul_go), .div_go_o(div_go),
		.a_mag_o(a_mag), .b_mag_o(b_mag), .dividend_o(dividend_raw),
		.unit_sel_o(unit_sel), .rsel_o(rsel), .neg_res_o(neg_res),
		.div_zero_o(div_zero), .div_ovf_o(div_ovf)
	);

	m_multiplier #(.XLEN(XLEN), .MUL_STAGES(MUL_STAGES)) u_mul (
		.clk_i, .rst_n_i, .go_i(mul_go), .a_i(a_mag), .b_i(b_mag),
		.product_o(product), .done_o(mul_done)
	);

	m_divider #(.XLEN(XLEN)) u_div (
		.clk_i, .rst_n_i, .go_i(div_go), .dividend_i(a_mag), .divisor_i(b_mag),
		.quotient_o(quotient), .remainder_o(remainder), .done_o(div_done)
	);

	m_result #(.XLEN(XLEN), .MUL_STAGES(MUL_STAGES)) u_result (
		.clk_i, .rst_n_i, .unit_sel_i(unit_sel), .rsel_i(rsel),
		.neg_res_i(neg_res), .div_zero_i(div_zero), .div_ovf_i(div_ovf),
		.dividend_i(dividend_raw), .product_i(product),
		.quotient_i(quotient), .remainder_i(remainder),
		.mul_done_i(mul_done), .div_done_i(div_done),
		.result_o, .done_o
	);

endmodule

// ==== source/m_result.sv ====
// result stage: sign correction, part select, divide corner cases, result register
`timescale 1ns/1ps

module m_result #(
	parameter int XLEN       = 32,
	parameter int MUL_STAGES = 2
) (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  m_uop_pkg::m_unit_sel_e unit_sel_i,
	input  m_uop_pkg::m_rsel_e     rsel_i,
	input  logic                   neg_res_i,
	input  logic                   div_zero_i,
	input  logic                   div_ovf_i,
	input  logic [XLEN-1:0]        dividend_i,
	input  logic [2*XLEN-1:0]      product_i,
	input  logic [XLEN-1:0]        quotient_i,
	input  logic [XLEN-1:0]        remainder_i,
	input  logic                   mul_done_i,
	input  logic                   div_done_i,
	output logic [XLEN-1:0]        result_o,
	output logic                   done_o
);
	import m_uop_pkg::*;

	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	// the done pulse timing below relies on a registered multiplier
	if (MUL_STAGES < 1) begin : g_stage_check
		$error("m_result: MUL_STAGES must be at least 1");
	end

	logic              unit_done;
	logic [2*XLEN-1:0] prod_s;
	logic [XLEN-1:0]   quo_s;
	logic [XLEN-1:0]   rem_s;
	logic [XLEN-1:0]   res_d;

	assign unit_done = (unit_sel_i == UNIT_MUL) ? mul_done_i : div_done_i;
	assign prod_s    = neg_res_i ? -product_i : product_i; // negate before the half select
	assign quo_s     = neg_res_i ? -quotient_i : quotient_i;
	assign rem_s     = neg_res_i ? -remainder_i : remainder_i;

	always_comb begin
		case (rsel_i)
			RSEL_LO:   res_d = prod_s[XLEN-1:0];
			RSEL_HI:   res_d = prod_s[2*XLEN-1:XLEN];
			RSEL_QUOT: res_d = div_zero_i ? '1 : (div_ovf_i ? MOST_NEG : quo_s);
			default:   res_d = div_zero_i ? dividend_i : (div_ovf_i ? '0 : rem_s);
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			result_o <= '0;
			done_o   <= 1'b0;
		end else begin
			done_o <= unit_done;
			if (unit_done) begin
				result_o <= res_d; // held until the next done
			end
		end
	end

endmodule

// ==== source/m_divider.sv ====
// restoring shift-subtract divider on unsigned magnitudes, one quotient bit per cycle
`timescale 1ns/1ps

module m_divider #(
	parameter int XLEN = 32
) (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            go_i,
	input  logic [XLEN-1:0] dividend_i,
	input  logic [XLEN-1:0] divisor_i,
	output logic [XLEN-1:0] quotient_o,
	output logic [XLEN-1:0] remainder_o,
	output logic            done_o
);

	logic [XLEN-1:0] rem_q;
	logic [XLEN-1:0] quo_q;   // dividend bits shift out, quotient bits shift in
	logic [XLEN-1:0] div_q;
	logic [XLEN-1:0] step_q;  // one-hot, bit k set while step k runs
	logic            active_q;
	logic            done_q;

	logic [XLEN-1:0] src_rem;
	logic [XLEN-1:0] src_quo;
	logic [XLEN-1:0] src_div;
	logic [XLEN:0]   shifted;
	logic [XLEN:0]   diff;
	logic            q_bit;
	logic [XLEN-1:0] next_rem;

	// step 0 runs on the go cycle straight from the inputs
	assign src_rem = go_i ? '0 : rem_q;
	assign src_quo = go_i ? dividend_i : quo_q;
	assign src_div = go_i ? divisor_i : div_q;

	assign shifted  = {src_rem, src_quo[XLEN-1]};
	assign diff     = shifted - {1'b0, src_div};
	assign q_bit    = ~diff[XLEN]; // borrow means restore
	assign next_rem = q_bit ? diff[XLEN-1:0] : shifted[XLEN-1:0];

	always_ff @(posedge clk_i) begin
		if (go_i || active_q) begin
			rem_q <= next_rem;
			quo_q <= {src_quo[XLEN-2:0], q_bit};
		end
		if (go_i) begin
			div_q <= divisor_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			step_q   <= '0;
			active_q <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (go_i) begin
				step_q   <= {{(XLEN-2){1'b0}}, 2'b10};
				active_q <= 1'b1;
			end else if (active_q) begin
				step_q <= step_q << 1;
				if (step_q[XLEN-1]) begin // last step
					active_q <= 1'b0;
					done_q   <= 1'b1;
				end
			end
		end
	end

	assign quotient_o  = quo_q;
	assign remainder_o = rem_q;
	assign done_o      = done_q;

endmodule

// ==== source/m_multiplier.sv ====
// unsigned XLEN x XLEN multiplier with a MUL_STAGES deep register pipeline
`timescale 1ns/1ps

module m_multiplier #(
	parameter int XLEN       = 32,
	parameter int MUL_STAGES = 2
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                go_i,
	input  logic [XLEN-1:0]     a_i,
	input  logic [XLEN-1:0]     b_i,
	output logic [2*XLEN-1:0]   product_o,
	output logic                done_o
);

	logic [2*XLEN-1:0]     prod_q [MUL_STAGES];
	logic [MUL_STAGES-1:0] valid_q;
	logic [2*XLEN-1:0]     full_prod;

	// retiming into the stage registers is left to synthesis
	assign full_prod = a_i * b_i;

	always_ff @(posedge clk_i) begin
		prod_q[0] <= full_prod;
		for (int i = 1; i < MUL_STAGES; i++) begin
			prod_q[i] <= prod_q[i-1];
		end
	end

	// valid tag follows the product down the pipe
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= go_i;
			for (int i = 1; i < MUL_STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	assign product_o = prod_q[MUL_STAGES-1];
	assign done_o    = valid_q[MUL_STAGES-1];

endmodule

// ==== source/m_decode.sv ====
// decode stage: operand magnitudes, result sign, corner-case flags and busy flag
`timescale 1ns/1ps

module m_decode #(
	parameter int XLEN = 32
) (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   start_i,
	input  m_isa_pkg::m_funct3_e   funct3_i,
	input  logic [XLEN-1:0]        rs1_i,
	input  logic [XLEN-1:0]        rs2_i,
	input  logic                   done_i,
	output logic                   busy_o,
	output logic                   mul_go_o,
	output logic                   div_go_o,
	output logic [XLEN-1:0]        a_mag_o,
	output logic [XLEN-1:0]        b_mag_o,
	output logic [XLEN-1:0]        dividend_o,
	output m_uop_pkg::m_unit_sel_e unit_sel_o,
	output m_uop_pkg::m_rsel_e     rsel_o,
	output logic                   neg_res_o,
	output logic                   div_zero_o,
	output logic                   div_ovf_o
);
	import m_isa_pkg::*;
	import m_uop_pkg::*;

	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic    accept;
	logic    is_div;
	logic    a_signed;
	logic    b_signed;
	logic    a_neg;
	logic    b_neg;
	m_rsel_e rsel_d;

	assign accept = start_i & ~busy_o; // starts while busy are dropped
	assign is_div = funct3_i[2];
	assign a_neg  = a_signed & rs1_i[XLEN-1];
	assign b_neg  = b_signed & rs2_i[XLEN-1];

	always_comb begin
		a_signed = 1'b0;
		b_signed = 1'b0;
		case (funct3_i)
			MULH, DIV, REM: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			MULHSU:  a_signed = 1'b1; // rs2 stays unsigned
			default: ;
		endcase
		case (funct3_i)
			MUL:                 rsel_d = RSEL_LO;
			MULH, MULHSU, MULHU: rsel_d = RSEL_HI;
			DIV, DIVU:           rsel_d = RSEL_QUOT;
			default:             rsel_d = RSEL_REM;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_o     <= 1'b0;
			mul_go_o   <= 1'b0;
			div_go_o   <= 1'b0;
			unit_sel_o <= UNIT_MUL;
			rsel_o     <= RSEL_LO;
			neg_res_o  <= 1'b0;
			div_zero_o <= 1'b0;
			div_ovf_o  <= 1'b0;
		end else begin
			mul_go_o <= accept & ~is_div;
			div_go_o <= accept & is_div;
			if (accept) begin
				busy_o     <= 1'b1;
				unit_sel_o <= is_div ? UNIT_DIV : UNIT_MUL;
				rsel_o     <= rsel_d;
				// remainder takes the dividend sign
				neg_res_o  <= (rsel_d == RSEL_REM) ? a_neg : (a_neg ^ b_neg);
				div_zero_o <= is_div & (rs2_i == '0);
				div_ovf_o  <= is_div & a_signed & (rs1_i == MOST_NEG) & (&rs2_i);
			end else if (done_i) begin
				busy_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			a_mag_o    <= a_neg ? -rs1_i : rs1_i;
			b_mag_o    <= b_neg ? -rs2_i : rs2_i;
			dividend_o <= rs1_i; // raw, for the zero-divisor remainder
		end
	end

endmodule

// ==== source/m_uop_pkg.sv ====
// decoded micro-op fields: execute unit select and result part select
package m_uop_pkg;

	// which execute block owns the operation
	typedef enum logic {
		UNIT_MUL = 1'b0,
		UNIT_DIV = 1'b1
	} m_unit_sel_e;

	// part of the raw result handed back
	typedef enum logic [1:0] {
		RSEL_LO   = 2'b00, // low half of product
		RSEL_HI   = 2'b01, // high half of product
		RSEL_QUOT = 2'b10,
		RSEL_REM  = 2'b11
	} m_rsel_e;

endpackage

// ==== source/m_isa_pkg.sv ====
// funct3 encodings of the RV32 M-extension operations
package m_isa_pkg;

	// standard funct3 order within OP with funct7 = 0000001
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} m_funct3_e;

endpackage
